/* hw/lsu_conf_pkg.sv */
package lsu_conf_pkg;

  // Data path width
  localparam int XLEN_W = 32;

  // ROB ids wrap around, ages compare by modular distance
  localparam int ROB_ID_W = 5;

  // L1D data array, word addressed
  localparam int DCACHE_WORDS  = 64;
  localparam int DCACHE_ADDR_W = 6;

endpackage

/* hw/lsu_pkg.sv */
package lsu_pkg;

  // ------------------------------------------------------------------------
  // Dispatch
  // ------------------------------------------------------------------------
  typedef enum logic {
    CAT_LD = 1'b0,
    CAT_ST = 1'b1
  } inst_cat_e;

  typedef struct packed {
    logic [6:0]                      preg;
    logic [lsu_conf_pkg::XLEN_W-8:0] rsvd;
  } ld_payload_t;

  typedef struct packed {
    logic [lsu_conf_pkg::XLEN_W-1:0] data;
  } st_payload_t;

  // Category selects the valid view
  typedef union packed {
    ld_payload_t ld;
    st_payload_t st;
  } disp_payload_u;

  typedef struct packed {
    logic                                   valid;
    inst_cat_e                              cat;
    logic [lsu_conf_pkg::ROB_ID_W-1:0]      rob_id;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
    disp_payload_u                          payload;
  } disp_t;

  typedef struct packed {
    logic                              valid;
    logic [lsu_conf_pkg::ROB_ID_W-1:0] rob_id;
  } commit_t;

  typedef struct packed {
    logic                              valid;
    logic [lsu_conf_pkg::ROB_ID_W-1:0] rob_id;
    logic                              is_load;
    logic [lsu_conf_pkg::XLEN_W-1:0]   data;
  } done_rpt_t;

  // ------------------------------------------------------------------------
  // Forwarding and L1D ports
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic                                   valid;
    logic [lsu_conf_pkg::ROB_ID_W-1:0]      rob_id;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
  } fwd_req_t;

  typedef struct packed {
    logic                            hit;
    logic [lsu_conf_pkg::XLEN_W-1:0] data;
  } fwd_resp_t;

  typedef struct packed {
    logic                                   valid;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
  } l1d_rd_req_t;

  typedef struct packed {
    logic                                   valid;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
    logic [lsu_conf_pkg::XLEN_W-1:0]        data;
  } l1d_wr_req_t;

  // True when a is older than b in the ROB
  function automatic logic rob_older(
    input logic [lsu_conf_pkg::ROB_ID_W-1:0] a,
    input logic [lsu_conf_pkg::ROB_ID_W-1:0] b
  );
    logic [lsu_conf_pkg::ROB_ID_W-1:0] diff;
    diff = a - b;
    return diff[lsu_conf_pkg::ROB_ID_W-1];
  endfunction

endpackage

/* hw/lsu_ldq.sv */
`timescale 1ns/1ps

module lsu_ldq #(
  parameter int LDQ_DEPTH = 4
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  lsu_pkg::disp_t                  i_disp,
  input  lsu_pkg::fwd_resp_t              i_fwd_resp,
  input  logic                            i_ld_grant,
  input  logic [lsu_conf_pkg::XLEN_W-1:0] i_rd_data,
  output logic                            o_full,
  output lsu_pkg::fwd_req_t               o_fwd_req,
  output lsu_pkg::l1d_rd_req_t            o_rd_req,
  output lsu_pkg::done_rpt_t              o_done_report
);

  localparam int IDX_W = $clog2(LDQ_DEPTH);

  typedef enum logic [1:0] {
    LD_WAIT,
    LD_RD,
    LD_DONE
  } ld_state_e;

  typedef struct packed {
    logic [lsu_conf_pkg::ROB_ID_W-1:0]      rob_id;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
    logic [lsu_conf_pkg::XLEN_W-1:0]        data;
  } ld_entry_t;

  logic [LDQ_DEPTH-1:0] r_valid;
  ld_state_e            r_state [LDQ_DEPTH];
  ld_entry_t            r_ent [LDQ_DEPTH];
  logic                 r_rd_pend;
  logic [IDX_W-1:0]     r_rd_idx;

  logic                                             w_alloc;
  logic [IDX_W-1:0]                                 w_alloc_idx;
  logic [LDQ_DEPTH-1:0][lsu_conf_pkg::ROB_ID_W-1:0] w_ids;
  logic [LDQ_DEPTH-1:0]                             w_wait_mask;
  logic [LDQ_DEPTH-1:0]                             w_done_mask;
  logic [IDX_W-1:0]                                 w_sel_idx;
  logic [IDX_W-1:0]                                 w_done_idx;
  logic                                             w_sel_vld;
  logic                                             w_fwd_hit;
  logic                                             w_issue;

  // Index of the oldest entry in mask
  function automatic logic [IDX_W-1:0] f_oldest(
    input logic [LDQ_DEPTH-1:0]                             mask,
    input logic [LDQ_DEPTH-1:0][lsu_conf_pkg::ROB_ID_W-1:0] ids
  );
    logic [IDX_W-1:0] idx;
    logic             found;
    idx   = '0;
    found = 1'b0;
    for (int i = 0; i < LDQ_DEPTH; i++) begin
      if (mask[i] && (!found || lsu_pkg::rob_older(ids[i], ids[idx]))) begin
        idx   = IDX_W'(i);
        found = 1'b1;
      end
    end
    return idx;
  endfunction

  always_comb begin
    w_alloc_idx = '0;
    for (int i = LDQ_DEPTH - 1; i >= 0; i--) begin
      w_ids[i]       = r_ent[i].rob_id;
      w_wait_mask[i] = r_valid[i] && (r_state[i] == LD_WAIT);
      w_done_mask[i] = r_valid[i] && (r_state[i] == LD_DONE);
      if (!r_valid[i]) begin
        w_alloc_idx = IDX_W'(i);
      end
    end
  end

  assign o_full  = &r_valid;
  assign w_alloc = i_disp.valid && (i_disp.cat == lsu_pkg::CAT_LD) && !o_full;

  // ------------------------------------------------------------------------
  // Issue: forwarding check first, then the read port
  // ------------------------------------------------------------------------
  assign w_sel_vld = |w_wait_mask;
  assign w_sel_idx = f_oldest(w_wait_mask, w_ids);
  assign w_fwd_hit = w_sel_vld && i_fwd_resp.hit;

  assign o_fwd_req.valid  = w_sel_vld;
  assign o_fwd_req.rob_id = r_ent[w_sel_idx].rob_id;
  assign o_fwd_req.addr   = r_ent[w_sel_idx].addr;

  assign o_rd_req.valid = w_sel_vld && !i_fwd_resp.hit;
  assign o_rd_req.addr  = r_ent[w_sel_idx].addr;
  // No grant means retry next cycle
  assign w_issue        = o_rd_req.valid && i_ld_grant;

  // Oldest finished load reports
  assign w_done_idx              = f_oldest(w_done_mask, w_ids);
  assign o_done_report.valid     = |w_done_mask;
  assign o_done_report.rob_id    = r_ent[w_done_idx].rob_id;
  assign o_done_report.is_load   = 1'b1;
  assign o_done_report.data      = r_ent[w_done_idx].data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= '0;
      r_rd_pend <= 1'b0;
      r_rd_idx  <= '0;
      for (int i = 0; i < LDQ_DEPTH; i++) begin
        r_state[i] <= LD_WAIT;
      end
    end else begin
      if (w_alloc) begin
        r_valid[w_alloc_idx] <= 1'b1;
        r_state[w_alloc_idx] <= LD_WAIT;
      end
      if (w_fwd_hit) begin
        r_state[w_sel_idx] <= LD_DONE;
      end else if (w_issue) begin
        r_state[w_sel_idx] <= LD_RD;
      end
      if (r_rd_pend) begin
        r_state[r_rd_idx] <= LD_DONE;
      end
      // Arbiter always takes load reports
      if (o_done_report.valid) begin
        r_valid[w_done_idx] <= 1'b0;
      end
      r_rd_pend <= w_issue;
      r_rd_idx  <= w_sel_idx;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_ent[w_alloc_idx].rob_id <= i_disp.rob_id;
      r_ent[w_alloc_idx].addr   <= i_disp.addr;
    end
    if (w_fwd_hit) begin
      r_ent[w_sel_idx].data <= i_fwd_resp.data;
    end
    if (r_rd_pend) begin
      r_ent[r_rd_idx].data <= i_rd_data;
    end
  end

  // A grant only answers a read from a valid entry
  a_rd_from_valid: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_ld_grant |-> o_rd_req.valid && r_valid[w_sel_idx]
  );

  // Read data only lands on an entry still waiting for it
  a_rd_resp_owned: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_rd_pend |-> r_valid[r_rd_idx] && (r_state[r_rd_idx] == LD_RD)
  );

endmodule

/* hw/lsu_stq.sv */
`timescale 1ns/1ps

module lsu_stq #(
  parameter int STQ_DEPTH = 4
) (
  input  logic                 i_clk,
  input  logic                 i_reset_n,
  input  lsu_pkg::disp_t       i_disp,
  input  lsu_pkg::commit_t     i_commit,
  input  lsu_pkg::fwd_req_t    i_fwd_req,
  input  logic                 i_st_rpt_ready,
  output logic                 o_full,
  output logic                 o_empty,
  output lsu_pkg::fwd_resp_t   o_fwd_resp,
  output lsu_pkg::l1d_wr_req_t o_wr_req,
  output lsu_pkg::done_rpt_t   o_done_report
);

  localparam int IDX_W = $clog2(STQ_DEPTH);

  typedef struct packed {
    logic [lsu_conf_pkg::ROB_ID_W-1:0]      rob_id;
    logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] addr;
    logic [lsu_conf_pkg::XLEN_W-1:0]        data;
  } st_entry_t;

  logic [STQ_DEPTH-1:0] r_valid;
  logic [STQ_DEPTH-1:0] r_rptd;
  logic [STQ_DEPTH-1:0] r_cmtd;
  st_entry_t            r_ent [STQ_DEPTH];
  logic [IDX_W-1:0]     r_head;
  logic [IDX_W-1:0]     r_tail;
  logic [IDX_W-1:0]     r_rpt_ptr;

  logic                 w_alloc;
  logic                 w_rpt_take;
  logic [STQ_DEPTH-1:0] w_cmt_hit;
  logic                 w_fwd_hit;
  logic [IDX_W-1:0]     w_fwd_idx;

  function automatic logic [IDX_W-1:0] f_next(input logic [IDX_W-1:0] ptr);
    return (ptr == IDX_W'(STQ_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign o_full  = &r_valid;
  assign o_empty = ~|r_valid;
  assign w_alloc = i_disp.valid && (i_disp.cat == lsu_pkg::CAT_ST) && !o_full;

  // Reports go out in dispatch order
  assign o_done_report.valid   = r_valid[r_rpt_ptr] && !r_rptd[r_rpt_ptr];
  assign o_done_report.rob_id  = r_ent[r_rpt_ptr].rob_id;
  assign o_done_report.is_load = 1'b0;
  assign o_done_report.data    = '0;
  assign w_rpt_take            = o_done_report.valid && i_st_rpt_ready;

  // Head drains once committed
  assign o_wr_req.valid = r_valid[r_head] && r_cmtd[r_head];
  assign o_wr_req.addr  = r_ent[r_head].addr;
  assign o_wr_req.data  = r_ent[r_head].data;

  // ------------------------------------------------------------------------
  // Forwarding: youngest store older than the load, same address
  // ------------------------------------------------------------------------
  always_comb begin
    w_fwd_hit = 1'b0;
    w_fwd_idx = '0;
    for (int i = 0; i < STQ_DEPTH; i++) begin
      w_cmt_hit[i] = i_commit.valid && r_valid[i] && (r_ent[i].rob_id == i_commit.rob_id);
      if (i_fwd_req.valid && r_valid[i] && (r_ent[i].addr == i_fwd_req.addr) &&
          lsu_pkg::rob_older(r_ent[i].rob_id, i_fwd_req.rob_id) &&
          (!w_fwd_hit || lsu_pkg::rob_older(r_ent[w_fwd_idx].rob_id, r_ent[i].rob_id))) begin
        w_fwd_hit = 1'b1;
        w_fwd_idx = IDX_W'(i);
      end
    end
  end

  assign o_fwd_resp.hit  = w_fwd_hit;
  assign o_fwd_resp.data = r_ent[w_fwd_idx].data;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid   <= '0;
      r_rptd    <= '0;
      r_cmtd    <= '0;
      r_head    <= '0;
      r_tail    <= '0;
      r_rpt_ptr <= '0;
    end else begin
      if (w_alloc) begin
        r_valid[r_tail] <= 1'b1;
        r_rptd[r_tail]  <= 1'b0;
        r_cmtd[r_tail]  <= 1'b0;
        r_tail          <= f_next(r_tail);
      end
      if (w_rpt_take) begin
        r_rptd[r_rpt_ptr] <= 1'b1;
        r_rpt_ptr         <= f_next(r_rpt_ptr);
      end
      for (int i = 0; i < STQ_DEPTH; i++) begin
        if (w_cmt_hit[i]) begin
          r_cmtd[i] <= 1'b1;
        end
      end
      if (o_wr_req.valid) begin
        r_valid[r_head] <= 1'b0;
        r_head          <= f_next(r_head);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_alloc) begin
      r_ent[r_tail].rob_id <= i_disp.rob_id;
      r_ent[r_tail].addr   <= i_disp.addr;
      r_ent[r_tail].data   <= i_disp.payload.st.data;
    end
  end

  // ROB may only commit a store whose done report already left
  a_commit_known: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_commit.valid |-> |(w_cmt_hit & r_rptd)
  );

endmodule

/* hw/lsu_dcache.sv */
`timescale 1ns/1ps

module lsu_dcache (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  lsu_pkg::l1d_rd_req_t            i_snoop_req,
  input  lsu_pkg::l1d_rd_req_t            i_ld_req,
  input  lsu_pkg::l1d_wr_req_t            i_wr_req,
  output logic                            o_ld_grant,
  output logic [lsu_conf_pkg::XLEN_W-1:0] o_rd_data,
  output logic                            o_snoop_resp_valid,
  output logic [lsu_conf_pkg::XLEN_W-1:0] o_snoop_resp_data
);

  logic [lsu_conf_pkg::XLEN_W-1:0] r_mem [lsu_conf_pkg::DCACHE_WORDS];
  logic [lsu_conf_pkg::XLEN_W-1:0] r_rd_data;
  logic                            r_snoop_vld;

  logic [lsu_conf_pkg::DCACHE_ADDR_W-1:0] w_rd_addr;

  // Snoop owns the read port whenever present
  assign o_ld_grant = i_ld_req.valid && !i_snoop_req.valid;
  assign w_rd_addr  = i_snoop_req.valid ? i_snoop_req.addr : i_ld_req.addr;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_snoop_vld <= 1'b0;
      for (int i = 0; i < lsu_conf_pkg::DCACHE_WORDS; i++) begin
        r_mem[i] <= '0;
      end
    end else begin
      r_snoop_vld <= i_snoop_req.valid;
      if (i_wr_req.valid) begin
        r_mem[i_wr_req.addr] <= i_wr_req.data;
      end
    end
  end

  // Same-cycle write to the read address is bypassed
  always_ff @(posedge i_clk) begin
    if (i_wr_req.valid && (i_wr_req.addr == w_rd_addr)) begin
      r_rd_data <= i_wr_req.data;
    end else begin
      r_rd_data <= r_mem[w_rd_addr];
    end
  end

  assign o_rd_data          = r_rd_data;
  assign o_snoop_resp_valid = r_snoop_vld;
  assign o_snoop_resp_data  = r_rd_data;

endmodule

/* hw/lsu_done_arbiter.sv */
`timescale 1ns/1ps

module lsu_done_arbiter (
  input  logic               i_clk,
  input  logic               i_reset_n,
  input  lsu_pkg::done_rpt_t i_ld_report,
  input  lsu_pkg::done_rpt_t i_st_report,
  output logic               o_st_rpt_ready,
  output lsu_pkg::done_rpt_t o_done_report
);

  lsu_pkg::done_rpt_t r_pend;
  lsu_pkg::done_rpt_t r_out;

  logic w_st_take;

  // Store side stalls while a parked report waits
  assign o_st_rpt_ready = !r_pend.valid;
  assign w_st_take      = i_st_report.valid && o_st_rpt_ready;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pend <= '0;
      r_out  <= '0;
    end else begin
      if (i_ld_report.valid) begin
        // Load wins, a colliding store is parked
        r_out <= i_ld_report;
        if (w_st_take) begin
          r_pend <= i_st_report;
        end
      end else if (r_pend.valid) begin
        r_out        <= r_pend;
        r_pend.valid <= 1'b0;
      end else begin
        r_out <= i_st_report;
      end
    end
  end

  assign o_done_report = r_out;

  // A parked store report survives until it is sent
  a_pend_held: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_pend.valid && i_ld_report.valid |=> r_pend.valid && $stable(r_pend.rob_id)
  );

endmodule

/* hw/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
  parameter int LDQ_DEPTH = 4,
  parameter int STQ_DEPTH = 4
) (
  input  logic                            i_clk,
  input  logic                            i_reset_n,
  input  lsu_pkg::disp_t                  i_disp,
  input  lsu_pkg::commit_t                i_commit,
  input  lsu_pkg::l1d_rd_req_t            i_snoop_req,
  output logic                            o_disp_ready,
  output lsu_pkg::done_rpt_t              o_done_report,
  output logic                            o_snoop_resp_valid,
  output logic [lsu_conf_pkg::XLEN_W-1:0] o_snoop_resp_data,
  output logic                            o_stq_empty
);

  logic                            w_ldq_full;
  logic                            w_stq_full;
  lsu_pkg::disp_t                  w_disp;
  lsu_pkg::fwd_req_t               w_fwd_req;
  lsu_pkg::fwd_resp_t              w_fwd_resp;
  lsu_pkg::l1d_rd_req_t            w_ld_rd_req;
  lsu_pkg::l1d_wr_req_t            w_wr_req;
  logic                            w_ld_grant;
  logic [lsu_conf_pkg::XLEN_W-1:0] w_rd_data;
  lsu_pkg::done_rpt_t              w_ld_report;
  lsu_pkg::done_rpt_t              w_st_report;
  logic                            w_st_rpt_ready;

  // ------------------------------------------------------------------------
  // Dispatch accepted only while both queues have room
  // ------------------------------------------------------------------------
  assign o_disp_ready = !(w_ldq_full || w_stq_full);

  always_comb begin
    w_disp       = i_disp;
    w_disp.valid = i_disp.valid && o_disp_ready;
  end

  lsu_ldq #(
    .LDQ_DEPTH(LDQ_DEPTH)
  ) u_ldq (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp        (w_disp),
    .i_fwd_resp    (w_fwd_resp),
    .i_ld_grant    (w_ld_grant),
    .i_rd_data     (w_rd_data),
    .o_full        (w_ldq_full),
    .o_fwd_req     (w_fwd_req),
    .o_rd_req      (w_ld_rd_req),
    .o_done_report (w_ld_report)
  );

  lsu_stq #(
    .STQ_DEPTH(STQ_DEPTH)
  ) u_stq (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_disp         (w_disp),
    .i_commit       (i_commit),
    .i_fwd_req      (w_fwd_req),
    .i_st_rpt_ready (w_st_rpt_ready),
    .o_full         (w_stq_full),
    .o_empty        (o_stq_empty),
    .o_fwd_resp     (w_fwd_resp),
    .o_wr_req       (w_wr_req),
    .o_done_report  (w_st_report)
  );

  lsu_dcache u_dcache (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_snoop_req        (i_snoop_req),
    .i_ld_req           (w_ld_rd_req),
    .i_wr_req           (w_wr_req),
    .o_ld_grant         (w_ld_grant),
    .o_rd_data          (w_rd_data),
    .o_snoop_resp_valid (o_snoop_resp_valid),
    .o_snoop_resp_data  (o_snoop_resp_data)
  );

  lsu_done_arbiter u_done_arbiter (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_ld_report    (w_ld_report),
    .i_st_report    (w_st_report),
    .o_st_rpt_ready (w_st_rpt_ready),
    .o_done_report  (o_done_report)
  );

endmodule

/* dv/lsu_tb.sv */
`timescale 1ns/1ps

module lsu_tb;

  localparam int   N_ROWS   = 40;
  localparam int   BP_ROW   = 20;
  localparam int   AW       = lsu_conf_pkg::DCACHE_ADDR_W;
  localparam int   WORDS    = lsu_conf_pkg::DCACHE_WORDS;
  localparam int   WD_LIMIT = N_ROWS * 20 + 200;
  localparam logic LD       = 1'b0;
  localparam logic ST       = 1'b1;

  typedef struct packed {
    logic                              cat;
    logic [lsu_conf_pkg::ROB_ID_W-1:0] rob;
    logic [AW-1:0]                     addr;
    logic [lsu_conf_pkg::XLEN_W-1:0]   data;
  } row_t;

  // ----------------------------------------------------------------------------
  // Stimulus table in program order: category, ROB id, address, store data
  // ----------------------------------------------------------------------------
  row_t tbl [N_ROWS] = '{
    '{LD, 5'd0,  6'h05, 32'h0},
    '{ST, 5'd1,  6'h01, 32'ha1a1_0001},
    '{LD, 5'd2,  6'h01, 32'h0},
    '{ST, 5'd3,  6'h02, 32'hb2b2_0002},
    '{ST, 5'd4,  6'h02, 32'hb2b2_0003},
    '{LD, 5'd5,  6'h02, 32'h0},
    '{LD, 5'd6,  6'h09, 32'h0},
    '{ST, 5'd7,  6'h03, 32'hc3c3_0004},
    '{LD, 5'd8,  6'h03, 32'h0},
    '{LD, 5'd9,  6'h01, 32'h0},
    '{ST, 5'd10, 6'h04, 32'hd4d4_0005},
    '{LD, 5'd11, 6'h04, 32'h0},
    '{ST, 5'd12, 6'h05, 32'he5e5_0006},
    '{LD, 5'd13, 6'h05, 32'h0},
    '{LD, 5'd14, 6'h05, 32'h0},
    '{ST, 5'd15, 6'h01, 32'ha1a1_0007},
    '{LD, 5'd16, 6'h01, 32'h0},
    '{LD, 5'd17, 6'h0a, 32'h0},
    '{ST, 5'd18, 6'h06, 32'hf6f6_0008},
    '{LD, 5'd19, 6'h07, 32'h0},
    // Store run with commits held, fills the store queue
    '{ST, 5'd20, 6'h10, 32'h1010_0009},
    '{ST, 5'd21, 6'h11, 32'h1111_000a},
    '{ST, 5'd22, 6'h12, 32'h1212_000b},
    '{ST, 5'd23, 6'h13, 32'h1313_000c},
    '{ST, 5'd24, 6'h10, 32'h1010_000d},
    '{ST, 5'd25, 6'h14, 32'h1414_000e},
    '{LD, 5'd26, 6'h10, 32'h0},
    '{LD, 5'd27, 6'h12, 32'h0},
    '{LD, 5'd28, 6'h14, 32'h0},
    '{ST, 5'd29, 6'h20, 32'h2020_000f},
    '{LD, 5'd30, 6'h20, 32'h0},
    '{ST, 5'd31, 6'h21, 32'h2121_0010},
    // ROB ids wrap from here
    '{LD, 5'd0,  6'h21, 32'h0},
    '{LD, 5'd1,  6'h03, 32'h0},
    '{ST, 5'd2,  6'h3f, 32'h3f3f_0011},
    '{LD, 5'd3,  6'h3f, 32'h0},
    '{LD, 5'd4,  6'h3e, 32'h0},
    '{ST, 5'd5,  6'h02, 32'hb2b2_0012},
    '{LD, 5'd6,  6'h02, 32'h0},
    '{LD, 5'd7,  6'h06, 32'h0}
  };

  logic                            i_clk       = 1'b0;
  logic                            i_reset_n   = 1'b0;
  lsu_pkg::disp_t                  i_disp      = '0;
  lsu_pkg::commit_t                i_commit    = '0;
  lsu_pkg::l1d_rd_req_t            i_snoop_req = '0;
  logic                            o_disp_ready;
  lsu_pkg::done_rpt_t              o_done_report;
  logic                            o_snoop_resp_valid;
  logic [lsu_conf_pkg::XLEN_W-1:0] o_snoop_resp_data;
  logic                            o_stq_empty;

  // Reference model
  logic [31:0] mem_model [WORDS]  = '{default: '0};
  logic [31:0] st_last [WORDS]    = '{default: '0};
  logic        st_seen [WORDS]    = '{default: 1'b0};
  logic [31:0] exp_data [N_ROWS]  = '{default: '0};
  logic        reported [N_ROWS]  = '{default: 1'b0};
  int          row_of_rob [32]    = '{default: -1};

  logic [15:0] lfsr_state     = 16'd51;
  logic        cmt_hold       = 1'b0;
  logic        bp_seen        = 1'b0;
  int          c_ptr          = 0;
  int          snoop_mode     = 0;
  int          snoop_cnt      = 0;
  int          sweep_idx      = 0;
  logic        snoop_chk      = 1'b0;
  logic        exp_snoop_vld  = 1'b0;
  logic        exp_snoop_chk  = 1'b0;
  logic [AW-1:0] exp_snoop_addr = '0;
  int          n_mismatch     = 0;
  int          n_other        = 0;

  lsu_top #(
    .LDQ_DEPTH(4),
    .STQ_DEPTH(4)
  ) UUT (
    .i_clk              (i_clk),
    .i_reset_n          (i_reset_n),
    .i_disp             (i_disp),
    .i_commit           (i_commit),
    .i_snoop_req        (i_snoop_req),
    .o_disp_ready       (o_disp_ready),
    .o_done_report      (o_done_report),
    .o_snoop_resp_valid (o_snoop_resp_valid),
    .o_snoop_resp_data  (o_snoop_resp_data),
    .o_stq_empty        (o_stq_empty)
  );

  always #2 i_clk = ~i_clk;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int v);
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = v * 2 + int'(lfsr_state[0]);
    end
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    n_mismatch++;
    $display("mismatch %s: got %h expected %h", name, got, exp);
  endtask

  function automatic lsu_pkg::disp_t make_disp(input row_t row);
    lsu_pkg::disp_t d;
    d        = '0;
    d.valid  = 1'b1;
    d.cat    = lsu_pkg::inst_cat_e'(row.cat);
    d.rob_id = row.rob;
    d.addr   = row.addr;
    if (row.cat == ST) begin
      d.payload.st.data = row.data;
    end else begin
      d.payload.ld.preg = {2'b00, row.rob};
    end
    return d;
  endfunction

  // Expected load data from program order at dispatch
  task automatic book_row(input int r);
    row_of_rob[tbl[r].rob] = r;
    if (tbl[r].cat == ST) begin
      st_seen[tbl[r].addr] = 1'b1;
      st_last[tbl[r].addr] = tbl[r].data;
    end else begin
      exp_data[r] = st_seen[tbl[r].addr] ? st_last[tbl[r].addr] : mem_model[tbl[r].addr];
    end
  endtask

  task automatic check_report();
    int r;
    r = row_of_rob[o_done_report.rob_id];
    if (r < 0 || reported[r]) begin
      n_other++;
      $display("unexpected or repeated done report for ROB id %h", o_done_report.rob_id);
    end else begin
      reported[r] = 1'b1;
      if (o_done_report.is_load !== (tbl[r].cat == LD)) begin
        report_mismatch($sformatf("o_done_report.is_load (ROB id %h)", o_done_report.rob_id),
                        32'(o_done_report.is_load), 32'(tbl[r].cat == LD));
      end
      if (tbl[r].cat == LD && o_done_report.data !== exp_data[r]) begin
        report_mismatch($sformatf("o_done_report.data (ROB id %h)", o_done_report.rob_id),
                        o_done_report.data, exp_data[r]);
      end
    end
  endtask

  task automatic check_reset_state();
    if (o_disp_ready !== 1'b1) begin
      report_mismatch("o_disp_ready", 32'(o_disp_ready), 32'h1);
    end
    if (o_stq_empty !== 1'b1) begin
      report_mismatch("o_stq_empty", 32'(o_stq_empty), 32'h1);
    end
    if (o_done_report.valid !== 1'b0) begin
      report_mismatch("o_done_report.valid", 32'(o_done_report.valid), 32'h0);
    end
    if (o_snoop_resp_valid !== 1'b0) begin
      report_mismatch("o_snoop_resp_valid", 32'(o_snoop_resp_valid), 32'h0);
    end
  endtask

  // ----------------------------------------------------------------------------
  // In-order ROB retire, stores get a commit pulse
  // ----------------------------------------------------------------------------
  always @(posedge i_clk) begin
    i_commit.valid <= 1'b0;
    if (i_reset_n && !cmt_hold && c_ptr < N_ROWS && reported[c_ptr]) begin
      if (tbl[c_ptr].cat == ST) begin
        i_commit.valid  <= 1'b1;
        i_commit.rob_id <= tbl[c_ptr].rob;
        mem_model[tbl[c_ptr].addr] = tbl[c_ptr].data;
      end
      c_ptr <= c_ptr + 1;
    end
  end

  // Snoops every third cycle during traffic, then a sweep of the array
  always @(posedge i_clk) begin
    i_snoop_req.valid <= 1'b0;
    snoop_chk         <= 1'b0;
    if (snoop_mode == 1) begin
      snoop_cnt <= snoop_cnt + 1;
      if (snoop_cnt % 3 == 0) begin
        i_snoop_req.valid <= 1'b1;
        i_snoop_req.addr  <= AW'(snoop_cnt);
      end
    end else if (snoop_mode == 2 && sweep_idx < WORDS) begin
      i_snoop_req.valid <= 1'b1;
      i_snoop_req.addr  <= AW'(sweep_idx);
      snoop_chk         <= 1'b1;
      sweep_idx         <= sweep_idx + 1;
    end
  end

  // Outputs sampled mid-cycle
  always @(negedge i_clk) begin
    if (o_snoop_resp_valid !== exp_snoop_vld) begin
      report_mismatch("o_snoop_resp_valid", 32'(o_snoop_resp_valid), 32'(exp_snoop_vld));
    end
    if (exp_snoop_vld && exp_snoop_chk && o_snoop_resp_data !== mem_model[exp_snoop_addr]) begin
      report_mismatch($sformatf("o_snoop_resp_data (addr %h)", exp_snoop_addr),
                      o_snoop_resp_data, mem_model[exp_snoop_addr]);
    end
    exp_snoop_vld  = i_snoop_req.valid;
    exp_snoop_addr = i_snoop_req.addr;
    exp_snoop_chk  = snoop_chk;
    if (o_done_report.valid) begin
      check_report();
    end
  end

  initial begin
    repeat (WD_LIMIT) @(posedge i_clk);
    n_other++;
    $display("timeout after %0d cycles", WD_LIMIT);
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    $display("tests failed");
    $finish;
  end

  initial begin
    int gap;
    int stall;
    repeat (10) @(posedge i_clk);
    i_reset_n <= 1'b1;
    @(negedge i_clk);
    check_reset_state();
    snoop_mode = 1;

    for (int r = 0; r < N_ROWS; r++) begin
      draw_bits(2, gap);
      repeat (gap) begin
        @(posedge i_clk);
        i_disp.valid <= 1'b0;
      end
      @(posedge i_clk);
      i_disp <= make_disp(tbl[r]);
      book_row(r);
      stall = 0;
      @(negedge i_clk);
      if (r == BP_ROW) begin
        cmt_hold = 1'b1;
      end
      // Word held while ready is low, commits resume after a few stalls
      while (!o_disp_ready) begin
        stall++;
        if (cmt_hold && stall >= 4) begin
          cmt_hold = 1'b0;
          bp_seen  = 1'b1;
        end
        @(negedge i_clk);
      end
    end
    @(posedge i_clk);
    i_disp.valid <= 1'b0;

    @(negedge i_clk);
    while (!(c_ptr == N_ROWS && o_stq_empty)) @(negedge i_clk);
    snoop_mode = 2;
    while (sweep_idx < WORDS) @(negedge i_clk);
    repeat (2) @(negedge i_clk);

    for (int r = 0; r < N_ROWS; r++) begin
      if (!reported[r]) begin
        n_other++;
        $display("row %0d with ROB id %h never reported done", r, tbl[r].rob);
      end
    end
    if (!bp_seen) begin
      n_other++;
      $display("dispatch ready never dropped while store commits were held");
    end
    $display("errors: %0d mismatches, %0d other failures", n_mismatch, n_other);
    if (n_mismatch + n_other == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* flist.f */
hw/lsu_conf_pkg.sv
hw/lsu_pkg.sv
hw/lsu_ldq.sv
hw/lsu_stq.sv
hw/lsu_dcache.sv
hw/lsu_done_arbiter.sv
hw/lsu_top.sv
dv/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    --top-module lsu_tb -Mdir obj_dir -f flist.f; then
  echo "verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vlsu_tb > "$LOG" 2>&1; then
  cat "$LOG"
  echo "simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -q "tests failed" "$LOG"; then
  exit 1
fi
exit 0
